// File: include/cvxif_params.svh
// ~~~~~~~~~~~~~~~~~~~~
// CVXIF parameters giving the widths and the custom opcode of the coprocessor
// ~~~~~~~~~~~~~~~~~~~~

`ifndef CVXIF_PARAMS_SVH
`define CVXIF_PARAMS_SVH

// Operand and result width
`define XLEN 32

// Width of the transaction id carried with each offloaded instruction
`define TRANS_ID_BITS 3

// Number of source operands sent with an issue request
`define X_NUM_RS 2

// Major opcode taken by the coprocessor (custom-0)
`define CUSTOM0_OPCODE 7'b0001011

`endif

// File: hdl/cvxif_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// CVXIF package with the coprocessor operations and exception causes
// ~~~~~~~~~~~~~~~~~~~~

package cvxif_pkg;

    // Coprocessor operations encoded as funct3[1:0]
    typedef enum logic [1:0] {
        OP_ADD    = 2'd0,
        OP_SUB    = 2'd1,
        OP_XOR    = 2'd2,
        OP_BOUNDS = 2'd3
    } copro_op_e;

    // Exception causes reported toward writeback
    // Values follow the RISC-V mcause numbering where one exists
    typedef enum logic [5:0] {
        EXC_NONE      = 6'd0,
        ILLEGAL_INSTR = 6'd2,
        BOUNDS_FAULT  = 6'd5
    } exc_cause_e;

endpackage

// File: hdl/copro_decoder.sv
// ~~~~~~~~~~~~~~~~~~~~
// Coprocessor decoder that accepts or rejects offloaded instructions
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "cvxif_params.svh"

module copro_decoder import cvxif_pkg::*; (
    // Issue request
    input  logic                      issue_valid_i,
    input  logic [31:0]               issue_instr_i,
    input  logic [`TRANS_ID_BITS-1:0] issue_id_i,
    input  logic [`XLEN-1:0]          issue_rs1_i,
    input  logic [`XLEN-1:0]          issue_rs2_i,
    // High while stage 2 of the pipeline holds a result
    input  logic                      stage2_busy_i,
    output logic                      issue_ready_o,
    output logic                      issue_accept_o,
    // Decoded instruction to the pipeline
    output logic                      dec_valid_o,
    output copro_op_e                 dec_op_o,
    output logic [`TRANS_ID_BITS-1:0] dec_id_o,
    output logic [`XLEN-1:0]          dec_rs1_o,
    output logic [`XLEN-1:0]          dec_rs2_o,
    output logic                      dec_we_o
);

    logic [6:0] opcode;
    logic [4:0] rd;
    logic [2:0] funct3;
    logic [6:0] funct7;

    // R-type fields
    assign opcode = issue_instr_i[6:0];
    assign rd     = issue_instr_i[11:7];
    assign funct3 = issue_instr_i[14:12];
    assign funct7 = issue_instr_i[31:25];

    // Only custom-0 with funct3 0..3 and a zero funct7
    assign issue_accept_o = (opcode == `CUSTOM0_OPCODE)
                            && !funct3[2]
                            && (funct7 == 7'd0);

    always_comb begin
        case (funct3[1:0])
            2'd0:    dec_op_o = OP_ADD;
            2'd1:    dec_op_o = OP_SUB;
            2'd2:    dec_op_o = OP_XOR;
            default: dec_op_o = OP_BOUNDS;
        endcase
    end

    // A rejection answers in the same cycle, so it must not land on a
    // cycle where stage 2 already drives the writeback port
    assign issue_ready_o = !(issue_valid_i && !issue_accept_o && stage2_busy_i);

    assign dec_valid_o = issue_valid_i && issue_ready_o && issue_accept_o;

    // Bounds check only reports and never writes rd
    assign dec_we_o = (rd != 5'd0) && (dec_op_o != OP_BOUNDS);

    assign dec_id_o  = issue_id_i;
    assign dec_rs1_o = issue_rs1_i;
    assign dec_rs2_o = issue_rs2_i;

endmodule

// File: hdl/copro_alu.sv
// ~~~~~~~~~~~~~~~~~~~~
// Coprocessor execution in a two-stage pipeline toward the result channel
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "cvxif_params.svh"

module copro_alu import cvxif_pkg::*; (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    // Decoded instruction
    input  logic                      dec_valid_i,
    input  copro_op_e                 dec_op_i,
    input  logic [`TRANS_ID_BITS-1:0] dec_id_i,
    input  logic [`XLEN-1:0]          dec_rs1_i,
    input  logic [`XLEN-1:0]          dec_rs2_i,
    input  logic                      dec_we_i,
    output logic                      stage2_busy_o,
    // Result channel
    output logic                      result_valid_o,
    output logic [`TRANS_ID_BITS-1:0] result_id_o,
    output logic [`XLEN-1:0]          result_data_o,
    output logic                      result_we_o,
    output logic                      result_exc_o,
    output exc_cause_e                result_exccode_o
);

    // Stage 1
    logic                      s1_valid;
    copro_op_e                 s1_op;
    logic [`TRANS_ID_BITS-1:0] s1_id;
    logic [`XLEN-1:0]          s1_rs1;
    logic [`XLEN-1:0]          s1_rs2;
    logic                      s1_we;

    // Stage 2 inputs
    logic [`XLEN-1:0]          alu_data;
    logic                      alu_fault;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= dec_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        s1_op  <= dec_op_i;
        s1_id  <= dec_id_i;
        s1_rs1 <= dec_rs1_i;
        s1_rs2 <= dec_rs2_i;
        s1_we  <= dec_we_i;
    end

    always_comb begin
        alu_fault = 1'b0;
        case (s1_op)
            OP_ADD:  alu_data = s1_rs1 + s1_rs2;
            OP_SUB:  alu_data = s1_rs1 - s1_rs2;
            OP_XOR:  alu_data = s1_rs1 ^ s1_rs2;
            default: begin
                // Unsigned bounds check faults unless rs1 is below rs2
                alu_data  = s1_rs1;
                alu_fault = !(s1_rs1 < s1_rs2);
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            result_valid_o <= 1'b0;
        end else begin
            result_valid_o <= s1_valid;
        end
    end

    always_ff @(posedge clk_i) begin
        result_id_o      <= s1_id;
        result_data_o    <= alu_data;
        result_we_o      <= s1_we;
        result_exc_o     <= alu_fault;
        result_exccode_o <= alu_fault ? BOUNDS_FAULT : EXC_NONE;
    end

    assign stage2_busy_o = result_valid_o;

endmodule

// File: hdl/cvxif_fu.sv
// ~~~~~~~~~~~~~~~~~~~~
// CVXIF functional unit sending issue requests out and results or rejections back
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "cvxif_params.svh"

module cvxif_fu import cvxif_pkg::*; (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    // From issue
    input  logic                      x_valid_i,
    output logic                      x_ready_o,
    input  logic [31:0]               x_off_instr_i,
    input  logic [`TRANS_ID_BITS-1:0] x_trans_id_i,
    input  logic [`XLEN-1:0]          x_operand_a_i,
    input  logic [`XLEN-1:0]          x_operand_b_i,
    // To writeback
    output logic [`TRANS_ID_BITS-1:0] x_trans_id_o,
    output logic [`XLEN-1:0]          x_result_o,
    output logic                      x_valid_o,
    output logic                      x_we_o,
    output logic                      x_exc_valid_o,
    output exc_cause_e                x_exc_cause_o,
    output logic [`XLEN-1:0]          x_exc_tval_o,
    // Issue request to the coprocessor
    output logic                      issue_valid_o,
    output logic [31:0]               issue_instr_o,
    output logic [`TRANS_ID_BITS-1:0] issue_id_o,
    output logic [`XLEN-1:0]          issue_rs1_o,
    output logic [`XLEN-1:0]          issue_rs2_o,
    input  logic                      issue_ready_i,
    input  logic                      issue_accept_i,
    // Always-ready result channel from the coprocessor
    input  logic                      result_valid_i,
    input  logic [`TRANS_ID_BITS-1:0] result_id_i,
    input  logic [`XLEN-1:0]          result_data_i,
    input  logic                      result_we_i,
    input  logic                      result_exc_i,
    input  exc_cause_e                result_exccode_i
);

    logic [`XLEN-1:0] rs [`X_NUM_RS];
    logic             reject;

    // Request fields stay zero while issue has nothing to offer
    always_comb begin
        issue_valid_o = 1'b0;
        issue_instr_o = '0;
        issue_id_o    = '0;
        for (int i = 0; i < `X_NUM_RS; i++) begin
            rs[i] = '0;
        end
        if (x_valid_i) begin
            issue_valid_o = 1'b1;
            issue_instr_o = x_off_instr_i;
            issue_id_o    = x_trans_id_i;
            rs[0]         = x_operand_a_i;
            rs[1]         = x_operand_b_i;
        end
    end

    assign issue_rs1_o = rs[0];
    assign issue_rs2_o = rs[1];
    assign x_ready_o   = issue_ready_i;

    // A transfer the coprocessor does not take
    assign reject = issue_valid_o && issue_ready_i && !issue_accept_i;

    // Rejection takes priority over a result
    // The decoder keeps it off cycles that carry a result
    always_comb begin
        if (reject) begin
            x_valid_o     = 1'b1;
            x_trans_id_o  = issue_id_o;
            x_result_o    = '0;
            x_we_o        = 1'b0;
            x_exc_valid_o = 1'b1;
            x_exc_cause_o = ILLEGAL_INSTR;
            x_exc_tval_o  = issue_instr_o;
        end else begin
            x_valid_o     = result_valid_i;
            x_trans_id_o  = result_valid_i ? result_id_i : '0;
            x_result_o    = result_valid_i ? result_data_i : '0;
            x_we_o        = result_valid_i && result_we_i;
            x_exc_valid_o = result_valid_i && result_exc_i;
            x_exc_cause_o = result_valid_i ? result_exccode_i : EXC_NONE;
            x_exc_tval_o  = '0;
        end
    end

endmodule

// File: hdl/cvxif_subsys.sv
// ~~~~~~~~~~~~~~~~~~~~
// CVXIF subsystem joining the functional unit, decoder and execution pipeline
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "cvxif_params.svh"

module cvxif_subsys import cvxif_pkg::*; (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    // Issue side
    input  logic                      x_valid_i,
    output logic                      x_ready_o,
    input  logic [31:0]               x_off_instr_i,
    input  logic [`TRANS_ID_BITS-1:0] x_trans_id_i,
    input  logic [`XLEN-1:0]          x_operand_a_i,
    input  logic [`XLEN-1:0]          x_operand_b_i,
    // Writeback side
    output logic [`TRANS_ID_BITS-1:0] x_trans_id_o,
    output logic [`XLEN-1:0]          x_result_o,
    output logic                      x_valid_o,
    output logic                      x_we_o,
    output logic                      x_exc_valid_o,
    output exc_cause_e                x_exc_cause_o,
    output logic [`XLEN-1:0]          x_exc_tval_o
);

    // Issue request
    logic                      issue_valid;
    logic [31:0]               issue_instr;
    logic [`TRANS_ID_BITS-1:0] issue_id;
    logic [`XLEN-1:0]          issue_rs1;
    logic [`XLEN-1:0]          issue_rs2;
    logic                      issue_ready;
    logic                      issue_accept;

    // Decoder to pipeline
    logic                      dec_valid;
    copro_op_e                 dec_op;
    logic [`TRANS_ID_BITS-1:0] dec_id;
    logic [`XLEN-1:0]          dec_rs1;
    logic [`XLEN-1:0]          dec_rs2;
    logic                      dec_we;
    logic                      stage2_busy;

    // Result channel
    logic                      result_valid;
    logic [`TRANS_ID_BITS-1:0] result_id;
    logic [`XLEN-1:0]          result_data;
    logic                      result_we;
    logic                      result_exc;
    exc_cause_e                result_exccode;

    cvxif_fu u_cvxif_fu (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .x_valid_i        (x_valid_i),
        .x_ready_o        (x_ready_o),
        .x_off_instr_i    (x_off_instr_i),
        .x_trans_id_i     (x_trans_id_i),
        .x_operand_a_i    (x_operand_a_i),
        .x_operand_b_i    (x_operand_b_i),
        .x_trans_id_o     (x_trans_id_o),
        .x_result_o       (x_result_o),
        .x_valid_o        (x_valid_o),
        .x_we_o           (x_we_o),
        .x_exc_valid_o    (x_exc_valid_o),
        .x_exc_cause_o    (x_exc_cause_o),
        .x_exc_tval_o     (x_exc_tval_o),
        .issue_valid_o    (issue_valid),
        .issue_instr_o    (issue_instr),
        .issue_id_o       (issue_id),
        .issue_rs1_o      (issue_rs1),
        .issue_rs2_o      (issue_rs2),
        .issue_ready_i    (issue_ready),
        .issue_accept_i   (issue_accept),
        .result_valid_i   (result_valid),
        .result_id_i      (result_id),
        .result_data_i    (result_data),
        .result_we_i      (result_we),
        .result_exc_i     (result_exc),
        .result_exccode_i (result_exccode)
    );

    copro_decoder u_copro_decoder (
        .issue_valid_i  (issue_valid),
        .issue_instr_i  (issue_instr),
        .issue_id_i     (issue_id),
        .issue_rs1_i    (issue_rs1),
        .issue_rs2_i    (issue_rs2),
        .stage2_busy_i  (stage2_busy),
        .issue_ready_o  (issue_ready),
        .issue_accept_o (issue_accept),
        .dec_valid_o    (dec_valid),
        .dec_op_o       (dec_op),
        .dec_id_o       (dec_id),
        .dec_rs1_o      (dec_rs1),
        .dec_rs2_o      (dec_rs2),
        .dec_we_o       (dec_we)
    );

    copro_alu u_copro_alu (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .dec_valid_i      (dec_valid),
        .dec_op_i         (dec_op),
        .dec_id_i         (dec_id),
        .dec_rs1_i        (dec_rs1),
        .dec_rs2_i        (dec_rs2),
        .dec_we_i         (dec_we),
        .stage2_busy_o    (stage2_busy),
        .result_valid_o   (result_valid),
        .result_id_o      (result_id),
        .result_data_o    (result_data),
        .result_we_o      (result_we),
        .result_exc_o     (result_exc),
        .result_exccode_o (result_exccode)
    );

endmodule

// File: dv/tb_cvxif_subsys.sv
// ~~~~~~~~~~~~~~~~~~~~
// Testbench for the CVXIF subsystem driving a table of offloaded instructions
// A monitor checks each writeback against the queue of expected results
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "cvxif_params.svh"

module tb_cvxif_subsys import cvxif_pkg::*; ();

    localparam int NUM_VEC = 16;
    localparam int READY_TIMEOUT = 8;
    localparam int DRAIN_TIMEOUT = 20;
    localparam logic [6:0] OPC = `CUSTOM0_OPCODE;

    typedef struct packed {
        logic             accept;
        logic [`XLEN-1:0] data;
        logic             we;
        logic             exc;
        exc_cause_e       cause;
        logic [`XLEN-1:0] tval;
    } expect_t;

    typedef struct packed {
        logic [31:0]               instr;
        logic [`XLEN-1:0]          a;
        logic [`XLEN-1:0]          b;
        logic                      gap;
        logic [`TRANS_ID_BITS-1:0] id;
        expect_t                   exp;
    } vector_t;

    // Outputs still owed by the DUT in order of due cycle
    typedef struct packed {
        int idx;
        int due;
    } pending_t;

    logic                      clk_i = 1'b0;
    logic                      rst_n_i;
    logic                      x_valid_i;
    logic                      x_ready_o;
    logic [31:0]               x_off_instr_i;
    logic [`TRANS_ID_BITS-1:0] x_trans_id_i;
    logic [`XLEN-1:0]          x_operand_a_i;
    logic [`XLEN-1:0]          x_operand_b_i;
    logic [`TRANS_ID_BITS-1:0] x_trans_id_o;
    logic [`XLEN-1:0]          x_result_o;
    logic                      x_valid_o;
    logic                      x_we_o;
    logic                      x_exc_valid_o;
    exc_cause_e                x_exc_cause_o;
    logic [`XLEN-1:0]          x_exc_tval_o;

    vector_t     vectors [NUM_VEC];
    string       vec_name [NUM_VEC];
    int          test_errs [NUM_VEC];
    pending_t    pending [$];
    int          nvec = 0;
    int          cycle = 0;
    int          errors = 0;
    int          checks = 0;
    int          tests_done = 0;
    logic        timed_out = 1'b0;
    logic [31:0] lfsr_state = 32'h6321;

    cvxif_subsys u_cvxif_subsys (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .x_valid_i     (x_valid_i),
        .x_ready_o     (x_ready_o),
        .x_off_instr_i (x_off_instr_i),
        .x_trans_id_i  (x_trans_id_i),
        .x_operand_a_i (x_operand_a_i),
        .x_operand_b_i (x_operand_b_i),
        .x_trans_id_o  (x_trans_id_o),
        .x_result_o    (x_result_o),
        .x_valid_o     (x_valid_o),
        .x_we_o        (x_we_o),
        .x_exc_valid_o (x_exc_valid_o),
        .x_exc_cause_o (x_exc_cause_o),
        .x_exc_tval_o  (x_exc_tval_o)
    );

    always #4 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle <= cycle + 1;
    end

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_word();
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < 32; i++) begin
            w = {w[30:0], lfsr_step()};
        end
        return w;
    endfunction

    function automatic logic [31:0] rtype(input logic [6:0] funct7, input logic [2:0] funct3,
                                          input logic [4:0] rd, input logic [6:0] opcode);
        return {funct7, 5'd2, 5'd1, funct3, rd, opcode};
    endfunction

    // Reference model of the coprocessor and the rejection path
    function automatic expect_t model(input logic [31:0] instr, input logic [`XLEN-1:0] a,
                                      input logic [`XLEN-1:0] b);
        expect_t    e;
        logic [2:0] f3;
        e = '0;
        f3 = instr[14:12];
        e.accept = (instr[6:0] == OPC) && (f3 <= 3'd3) && (instr[31:25] == 7'd0);
        if (!e.accept) begin
            e.exc   = 1'b1;
            e.cause = ILLEGAL_INSTR;
            e.tval  = instr;
        end else if (f3 == 3'd3) begin
            e.data = a;
            if (a >= b) begin
                e.exc   = 1'b1;
                e.cause = BOUNDS_FAULT;
            end
        end else begin
            e.we = (instr[11:7] != 5'd0);
            case (f3)
                3'd0:    e.data = a + b;
                3'd1:    e.data = a - b;
                default: e.data = a ^ b;
            endcase
        end
        return e;
    endfunction

    task automatic add_vec(input string name, input logic [31:0] instr,
                           input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] b,
                           input logic gap);
        vec_name[nvec]      = name;
        vectors[nvec].instr = instr;
        vectors[nvec].a     = a;
        vectors[nvec].b     = b;
        vectors[nvec].gap   = gap;
        vectors[nvec].id    = nvec[2:0];
        vectors[nvec].exp   = model(instr, a, b);
        test_errs[nvec]     = 0;
        nvec++;
    endtask

    task automatic add_random(input string name, input logic [31:0] instr, input logic gap);
        logic [`XLEN-1:0] ra;
        logic [`XLEN-1:0] rb;
        ra = rand_word();
        rb = rand_word();
        add_vec(name, instr, ra, rb, gap);
    endtask

    task automatic build_vectors();
        add_random("add", rtype(7'd0, 3'd0, 5'd5, OPC), 1'b0);
        add_random("sub", rtype(7'd0, 3'd1, 5'd6, OPC), 1'b0);
        add_random("xor rd0", rtype(7'd0, 3'd2, 5'd0, OPC), 1'b0);
        add_vec("bounds in range", rtype(7'd0, 3'd3, 5'd7, OPC), 32'd10, 32'd20, 1'b0);
        add_vec("bounds fault", rtype(7'd0, 3'd3, 5'd7, OPC), 32'd20, 32'd20, 1'b1);
        add_vec("bad opcode", rtype(7'd0, 3'd0, 5'd5, 7'b0110011), 32'd1, 32'd2, 1'b1);
        add_vec("funct3 5", rtype(7'd0, 3'd5, 5'd5, OPC), 32'd3, 32'd4, 1'b0);
        add_vec("funct7 set", rtype(7'd1, 3'd0, 5'd5, OPC), 32'd5, 32'd6, 1'b0);
        // Three accepted in a row and then a rejection that meets two results
        add_random("add b2b", rtype(7'd0, 3'd0, 5'd1, OPC), 1'b1);
        add_random("sub b2b", rtype(7'd0, 3'd1, 5'd2, OPC), 1'b0);
        add_random("xor b2b", rtype(7'd0, 3'd2, 5'd3, OPC), 1'b0);
        add_vec("illegal held", rtype(7'd32, 3'd0, 5'd4, OPC), 32'd7, 32'd8, 1'b0);
        add_random("add", rtype(7'd0, 3'd0, 5'd9, OPC), 1'b1);
        add_vec("illegal after gap", rtype(7'd0, 3'd7, 5'd4, OPC), 32'd9, 32'd1, 1'b1);
        add_random("bounds random", rtype(7'd0, 3'd3, 5'd10, OPC), 1'b0);
        add_random("add rd0", rtype(7'd0, 3'd0, 5'd0, OPC), 1'b1);
    endtask

    task automatic record_error(input int idx, input string msg);
        errors++;
        test_errs[idx]++;
        $display("Fail t=%0d ns: test %0d %s", $time, idx, msg);
    endtask

    task automatic check_data(input int idx, input string what,
                              input logic [`XLEN-1:0] got, input logic [`XLEN-1:0] exp);
        checks++;
        if (got !== exp) begin
            record_error(idx, $sformatf("%s got %h expected %h", what, got, exp));
        end
    endtask

    task automatic check_id(input int idx, input logic [`TRANS_ID_BITS-1:0] got,
                            input logic [`TRANS_ID_BITS-1:0] exp);
        checks++;
        if (got !== exp) begin
            record_error(idx, $sformatf("x_trans_id_o got %0d expected %0d", got, exp));
        end
    endtask

    task automatic check_flag(input int idx, input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            record_error(idx, $sformatf("%s got %b expected %b", what, got, exp));
        end
    endtask

    task automatic check_cause(input int idx, input exc_cause_e got, input exc_cause_e exp);
        checks++;
        if (got !== exp) begin
            record_error(idx, $sformatf("x_exc_cause_o got %0d expected %s", got, exp.name()));
        end
    endtask

    task automatic check_cycle(input int idx, input int got, input int exp);
        checks++;
        if (got != exp) begin
            record_error(idx, $sformatf("output in cycle %0d expected in cycle %0d", got, exp));
        end
    endtask

    task automatic report_test(input int idx);
        tests_done++;
        if (test_errs[idx] == 0) begin
            $display("test %0d %s: ok", idx, vec_name[idx]);
        end else begin
            $display("test %0d %s: %0d errors", idx, vec_name[idx], test_errs[idx]);
        end
    endtask

    // Ready drops only for a rejection that meets a result leaving stage 2
    function automatic logic ready_expected(input int idx);
        logic busy;
        busy = 1'b0;
        foreach (pending[k]) begin
            if (pending[k].due == cycle && vectors[pending[k].idx].exp.accept) begin
                busy = 1'b1;
            end
        end
        return vectors[idx].exp.accept || !busy;
    endfunction

    task automatic push_pending(input int idx, input int due);
        pending_t p;
        int       pos;
        p.idx = idx;
        p.due = due;
        pos = pending.size();
        while (pos > 0 && pending[pos-1].due > due) begin
            pos--;
        end
        pending.insert(pos, p);
    endtask

    task automatic check_output(input pending_t p);
        expect_t e;
        e = vectors[p.idx].exp;
        check_cycle(p.idx, cycle, p.due);
        check_id(p.idx, x_trans_id_o, vectors[p.idx].id);
        check_data(p.idx, "x_result_o", x_result_o, e.data);
        check_flag(p.idx, "x_we_o", x_we_o, e.we);
        check_flag(p.idx, "x_exc_valid_o", x_exc_valid_o, e.exc);
        check_cause(p.idx, x_exc_cause_o, e.cause);
        check_data(p.idx, "x_exc_tval_o", x_exc_tval_o, e.tval);
        report_test(p.idx);
    endtask

    // Writeback monitor sampling mid cycle
    always @(negedge clk_i) begin : monitor
        pending_t head;
        if (x_valid_o !== 1'b0 && x_valid_o !== 1'b1) begin
            errors++;
            $display("x_valid_o is unknown at %0d ns", $time);
        end else if (x_valid_o) begin
            if (pending.size() == 0) begin
                errors++;
                $display("Fail t=%0d ns: x_valid_o high with no result pending", $time);
            end else begin
                head = pending.pop_front();
                check_output(head);
            end
        end else if (pending.size() != 0 && pending[0].due < cycle) begin
            head = pending.pop_front();
            record_error(head.idx, "no output in its due cycle");
            report_test(head.idx);
        end
    end

    task automatic run_vectors();
        int waited;
        for (int i = 0; i < nvec; i++) begin
            if (vectors[i].gap) begin
                x_valid_i = 1'b0;
                @(posedge clk_i);
                #1;
            end
            x_valid_i     = 1'b1;
            x_off_instr_i = vectors[i].instr;
            x_trans_id_i  = vectors[i].id;
            x_operand_a_i = vectors[i].a;
            x_operand_b_i = vectors[i].b;
            waited = 0;
            #2;
            check_flag(i, "x_ready_o", x_ready_o, ready_expected(i));
            while (x_ready_o !== 1'b1 && waited < READY_TIMEOUT) begin
                @(posedge clk_i);
                #3;
                waited++;
                check_flag(i, "x_ready_o", x_ready_o, ready_expected(i));
            end
            if (x_ready_o !== 1'b1) begin
                $display("Timeout: x_ready_o stayed low for test %0d", i);
                timed_out = 1'b1;
                x_valid_i = 1'b0;
                return;
            end
            push_pending(i, vectors[i].exp.accept ? cycle + 2 : cycle);
            @(posedge clk_i);
            #1;
        end
        x_valid_i = 1'b0;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (pending.size() != 0 && waited < DRAIN_TIMEOUT) begin
            @(posedge clk_i);
            waited++;
        end
        if (pending.size() != 0) begin
            $display("Timeout: %0d results never reached writeback", pending.size());
            timed_out = 1'b1;
        end
    endtask

    initial begin
        rst_n_i       = 1'b0;
        x_valid_i     = 1'b0;
        x_off_instr_i = '0;
        x_trans_id_i  = '0;
        x_operand_a_i = '0;
        x_operand_b_i = '0;
        build_vectors();
        repeat (5) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
        run_vectors();
        drain();
        // Idle tail in which the monitor flags any stray output
        repeat (6) @(posedge clk_i);
        $display("Summary: %0d of %0d tests done, %0d checks, %0d errors",
                 tests_done, nvec, checks, errors);
        if (errors == 0 && !timed_out && tests_done == nvec) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+include
hdl/cvxif_pkg.sv
hdl/copro_decoder.sv
hdl/copro_alu.sv
hdl/cvxif_fu.sv
hdl/cvxif_subsys.sv
dv/tb_cvxif_subsys.sv

// File: Makefile
# Verilator build and run for the CVXIF subsystem

VERILATOR ?= verilator
TOP       := tb_cvxif_subsys
FILELIST  := project.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --top-module $(TOP) --Mdir $(OBJ_DIR)

SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))
HEADERS   := $(wildcard include/*.svh)

.PHONY: all run clean

all: $(SIM)

# Rebuild only when a source, header or the file list changes
$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx '=== PASS ==='

clean:
	rm -rf $(OBJ_DIR)
